//--- Makefile
TOP := tb_axil_sram
LOG := sim.log

.PHONY: all run lint clean

all: run

# The log decides the result, the simulator's own status is not used
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test OK$$" $(LOG)

obj_dir/V$(TOP): build.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f build.f --top-module axil_sram_top

clean:
	rm -rf obj_dir $(LOG)

//--- bench/sram_chip_model.sv
`include "sram_defines.svh"

module sram_chip_model
  import sram_pkg::*;
(
  input  sram_pins_t                  pins,
  inout  wire [`SRAM_DATA_BITS-1:0]   data
);

  localparam int DEPTH = 1 << `SRAM_ADDR_BITS;

  logic [`SRAM_DATA_BITS-1:0]   mem [DEPTH];
  logic                         rd_en;
  wire                          we_n;

  // Power-up contents, every address bit shows up in the word
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = 16'(i) ^ 16'(i >> 14) ^ 16'hc3a5;
    end
  end

  assign we_n  = pins.we_n;
  assign rd_en = !pins.ce_n && !pins.oe_n && pins.we_n && !(pins.lb_n && pins.ub_n);

  // Output follows the address while enabled
  assign data = rd_en ? mem[pins.addr] : {`SRAM_DATA_BITS{1'bz}};

  // Write is taken on the rising edge of we_n
  always @(posedge we_n) begin
    if (!pins.ce_n) begin
      if (!pins.lb_n) begin
        mem[pins.addr][7:0] <= data[7:0];
      end
      if (!pins.ub_n) begin
        mem[pins.addr][15:8] <= data[15:8];
      end
    end
  end

endmodule

//--- bench/tb_axil_sram.sv
`include "sram_defines.svh"

module tb_axil_sram
  import sram_pkg::*;
();

  localparam int TIMEOUT  = 100;
  localparam int KEY_BITS = `SRAM_BANK_BITS + `SRAM_ADDR_BITS;

  // Bank number above the word offset
  typedef logic [KEY_BITS-1:0] key_t;

  logic                                        axi_aclk;
  logic                                        axi_aresetn;
  logic [`AXI_ADDR_BITS-1:0]                   s_axi_awaddr;
  logic                                        s_axi_awvalid;
  logic                                        s_axi_awready;
  logic [`SRAM_DATA_BITS-1:0]                  s_axi_wdata;
  logic [`SRAM_STRB_BITS-1:0]                  s_axi_wstrb;
  logic                                        s_axi_wvalid;
  logic                                        s_axi_wready;
  logic [1:0]                                  s_axi_bresp;
  logic                                        s_axi_bvalid;
  logic                                        s_axi_bready;
  logic [`AXI_ADDR_BITS-1:0]                   s_axi_araddr;
  logic                                        s_axi_arvalid;
  logic                                        s_axi_arready;
  logic [`SRAM_DATA_BITS-1:0]                  s_axi_rdata;
  logic [1:0]                                  s_axi_rresp;
  logic                                        s_axi_rvalid;
  logic                                        s_axi_rready;
  sram_pins_t [`SRAM_BANKS-1:0]                sram_pins;
  wire [`SRAM_BANKS-1:0][`SRAM_DATA_BITS-1:0]  sram_data;

  logic [`SRAM_DATA_BITS-1:0] ref_mem [key_t];

  axil_sram_top u_dut (.*);

  for (genvar b = 0; b < `SRAM_BANKS; b++) begin : g_chip
    sram_chip_model u_chip (
      .pins (sram_pins[b]),
      .data (sram_data[b])
    );
  end

  initial begin
    axi_aclk = 1'b0;
    forever #20 axi_aclk = ~axi_aclk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Test FAILED");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("ERR %0t: %s", $time, msg));
  endtask

  task automatic check_wait(input int n, input string what);
    if (n >= TIMEOUT) begin
      abort_run($sformatf("Timed out after %0d cycles waiting for %s", n, what));
    end
  endtask

  function automatic logic [`AXI_ADDR_BITS-1:0] byte_addr(input key_t key);
    return {key, 1'b0};
  endfunction

  function automatic logic [15:0] apply_strobes(input logic [15:0] old,
                                                input logic [15:0] wdata,
                                                input logic [1:0] strb);
    logic [15:0] res;
    res = old;
    if (strb[0]) begin
      res[7:0] = wdata[7:0];
    end
    if (strb[1]) begin
      res[15:8] = wdata[15:8];
    end
    return res;
  endfunction

  function automatic logic [15:0] expected_word(input key_t key);
    return ref_mem.exists(key) ? ref_mem[key] : 16'hxxxx;
  endfunction

  task automatic issue_write(input key_t key, input logic [15:0] wdata, input logic [1:0] strb);
    int n;
    s_axi_awaddr  = byte_addr(key);
    s_axi_wdata   = wdata;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    n = 0;
    @(posedge axi_aclk);
    while (!(s_axi_awready && s_axi_wready)) begin
      n++;
      check_wait(n, "write address and data ready");
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
  endtask

  task automatic issue_read(input key_t key);
    int n;
    s_axi_araddr  = byte_addr(key);
    s_axi_arvalid = 1'b1;
    n = 0;
    @(posedge axi_aclk);
    while (!s_axi_arready) begin
      n++;
      check_wait(n, "read address ready");
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
    s_axi_arvalid = 1'b0;
  endtask

  // hold > 0 keeps bready low that many cycles after bvalid
  task automatic collect_write(input int hold);
    int n;
    s_axi_bready = (hold == 0);
    n = 0;
    @(posedge axi_aclk);
    while (!s_axi_bvalid) begin
      n++;
      check_wait(n, "write response valid");
      @(posedge axi_aclk);
    end
    if (hold > 0) begin
      repeat (hold) @(negedge axi_aclk);
      s_axi_bready = 1'b1;
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
  endtask

  task automatic collect_read(input key_t key, input logic [15:0] exp, input int hold);
    int n;
    s_axi_rready = (hold == 0);
    n = 0;
    @(posedge axi_aclk);
    while (!s_axi_rvalid) begin
      n++;
      check_wait(n, "read data valid");
      @(posedge axi_aclk);
    end
    assert (s_axi_rdata === exp)
      else report_mismatch($sformatf("read of %h returned %h, expected %h",
                                     byte_addr(key), s_axi_rdata, exp));
    if (hold > 0) begin
      repeat (hold) @(negedge axi_aclk);
      s_axi_rready = 1'b1;
      @(posedge axi_aclk);
    end
    @(negedge axi_aclk);
  endtask

  task automatic write_word(input key_t key, input logic [15:0] wdata,
                            input logic [1:0] strb, input int hold);
    issue_write(key, wdata, strb);
    collect_write(hold);
    ref_mem[key] = apply_strobes(expected_word(key), wdata, strb);
  endtask

  task automatic read_check(input key_t key, input int hold);
    issue_read(key);
    collect_read(key, expected_word(key), hold);
  endtask

  assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else report_mismatch("rvalid dropped or rdata changed under back-pressure");

  assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else report_mismatch("bvalid dropped under back-pressure");

  assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_rvalid || s_axi_bvalid |-> !s_axi_arready && !s_axi_awready)
    else report_mismatch("address ready high while a response is pending");

  assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_rvalid |-> s_axi_rresp == 2'b00)
    else report_mismatch("rresp is not OKAY");

  assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
    s_axi_bvalid |-> s_axi_bresp == 2'b00)
    else report_mismatch("bresp is not OKAY");

  initial begin
    key_t        keys [$];
    key_t        key;
    logic [15:0] wdata;
    logic [15:0] old;
    int          hold;
    void'($urandom(85177));
    axi_aresetn   = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b1;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b1;
    repeat (10) @(negedge axi_aclk);
    axi_aresetn = 1'b1;
    @(negedge axi_aclk);

    assert (!s_axi_bvalid && !s_axi_rvalid)
      else report_mismatch("response valid high after reset");
    assert (s_axi_awready && s_axi_wready && s_axi_arready)
      else report_mismatch("ready low after reset");
    for (int b = 0; b < `SRAM_BANKS; b++) begin
      assert (sram_pins[b].ce_n)
        else report_mismatch($sformatf("bank %0d ce_n low after reset", b));
      assert (sram_pins[b].oe_n && sram_pins[b].we_n)
        else report_mismatch($sformatf("bank %0d oe_n or we_n low after reset", b));
      assert (sram_pins[b].lb_n && sram_pins[b].ub_n)
        else report_mismatch($sformatf("bank %0d byte enable low after reset", b));
      assert (sram_data[b] === {`SRAM_DATA_BITS{1'bz}})
        else report_mismatch($sformatf("bank %0d data bus driven after reset", b));
    end

    // Full-word writes followed by a read of each
    for (int i = 0; i < 12; i++) begin
      key = key_t'($urandom);
      write_word(key, 16'($urandom), 2'b11, 0);
      keys.push_back(key);
    end
    foreach (keys[i]) read_check(keys[i], 0);

    // Single byte lanes with every data bit flipped
    wdata = ~expected_word(keys[0]);
    write_word(keys[0], wdata, 2'b01, 0);
    read_check(keys[0], 0);
    wdata = ~expected_word(keys[0]);
    write_word(keys[0], wdata, 2'b10, 0);
    read_check(keys[0], 0);

    // Same offset in every bank
    key   = key_t'($urandom);
    wdata = 16'($urandom);
    for (int b = 0; b < `SRAM_BANKS; b++) begin
      key[KEY_BITS-1 -: `SRAM_BANK_BITS] = b[`SRAM_BANK_BITS-1:0];
      write_word(key, wdata + 16'(b) * 16'h1111, 2'b11, 0);
    end
    for (int b = 0; b < `SRAM_BANKS; b++) begin
      key[KEY_BITS-1 -: `SRAM_BANK_BITS] = b[`SRAM_BANK_BITS-1:0];
      read_check(key, 0);
    end

    // Read and write to one word in the same cycle
    key   = keys[1];
    old   = expected_word(key);
    wdata = ~old;
    s_axi_araddr  = byte_addr(key);
    s_axi_arvalid = 1'b1;
    s_axi_awaddr  = byte_addr(key);
    s_axi_wdata   = wdata;
    s_axi_wstrb   = 2'b11;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    @(posedge axi_aclk);
    assert (s_axi_arready && !s_axi_awready && !s_axi_wready)
      else report_mismatch("write accepted ahead of a simultaneous read");
    @(negedge axi_aclk);
    s_axi_arvalid = 1'b0;
    collect_read(key, old, 0);
    issue_write(key, wdata, 2'b11);
    collect_write(0);
    ref_mem[key] = wdata;
    read_check(key, 0);

    // Back-pressure on both response channels
    for (int i = 0; i < 4; i++) begin
      hold = 1 + int'($urandom % 8);
      write_word(keys[i + 2], 16'($urandom), 2'b11, hold);
      hold = 1 + int'($urandom % 8);
      read_check(keys[i + 2], hold);
    end

    $display("Test OK");
    $finish;
  end

endmodule

//--- build.f
+incdir+verilog
verilog/sram_pkg.sv
verilog/axil_sram_frontend.sv
verilog/sram_bank_ctrl.sv
verilog/bank_rsp_merge.sv
verilog/axil_sram_top.sv
bench/sram_chip_model.sv
bench/tb_axil_sram.sv

//--- verilog/axil_sram_frontend.sv
`include "sram_defines.svh"

module axil_sram_frontend
  import sram_pkg::*;
(
  input  logic                        axi_aclk,
  input  logic                        axi_aresetn,

  input  logic [`AXI_ADDR_BITS-1:0]   s_axi_awaddr,
  input  logic                        s_axi_awvalid,
  output logic                        s_axi_awready,

  input  logic [`SRAM_DATA_BITS-1:0]  s_axi_wdata,
  input  logic [`SRAM_STRB_BITS-1:0]  s_axi_wstrb,
  input  logic                        s_axi_wvalid,
  output logic                        s_axi_wready,

  output logic [1:0]                  s_axi_bresp,
  output logic                        s_axi_bvalid,
  input  logic                        s_axi_bready,

  input  logic [`AXI_ADDR_BITS-1:0]   s_axi_araddr,
  input  logic                        s_axi_arvalid,
  output logic                        s_axi_arready,

  output logic [`SRAM_DATA_BITS-1:0]  s_axi_rdata,
  output logic [1:0]                  s_axi_rresp,
  output logic                        s_axi_rvalid,
  input  logic                        s_axi_rready,

  output bank_req_t                   bank_req,
  output logic [`SRAM_BANKS-1:0]      bank_sel_req,
  input  bank_rsp_t                   merged_rsp
);

  axil_state_e                  state;
  logic                         idle;
  logic                         wr_pair;
  logic                         rd_accept;
  logic                         wr_accept;
  logic [`AXI_ADDR_BITS-1:0]    acc_addr;
  logic [`SRAM_BANK_BITS-1:0]   acc_bank;
  logic [`SRAM_BANKS-1:0]       acc_onehot;
  logic                         rvalid_q;
  logic                         bvalid_q;
  logic [`SRAM_DATA_BITS-1:0]   rdata_q;

  assign idle    = (state == AXIL_IDLE);
  assign wr_pair = s_axi_awvalid && s_axi_wvalid;

  // Read wins a tie with a write
  assign rd_accept = idle && s_axi_arvalid;
  assign wr_accept = idle && !s_axi_arvalid && wr_pair;

  // Write channels only complete together, never one alone
  assign s_axi_arready = idle;
  assign s_axi_awready = idle && !s_axi_arvalid && (wr_pair || !s_axi_awvalid);
  assign s_axi_wready  = idle && !s_axi_arvalid && (wr_pair || !s_axi_wvalid);

  assign acc_addr   = s_axi_arvalid ? s_axi_araddr : s_axi_awaddr;
  assign acc_bank   = acc_addr[`AXI_ADDR_BITS-1 -: `SRAM_BANK_BITS];
  assign acc_onehot = {{(`SRAM_BANKS-1){1'b0}}, 1'b1} << acc_bank;

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state        <= AXIL_IDLE;
      bank_sel_req <= '0;
      rvalid_q     <= 1'b0;
      bvalid_q     <= 1'b0;
    end else begin
      bank_sel_req <= '0;
      case (state)
        AXIL_IDLE: begin
          if (rd_accept) begin
            bank_sel_req <= acc_onehot;
            state        <= AXIL_READ_WAIT;
          end else if (wr_accept) begin
            bank_sel_req <= acc_onehot;
            state        <= AXIL_WRITE_WAIT;
          end
        end
        AXIL_READ_WAIT: begin
          if (merged_rsp.done) begin
            rvalid_q <= 1'b1;
            state    <= AXIL_READ_RESP;
          end
        end
        AXIL_WRITE_WAIT: begin
          if (merged_rsp.done) begin
            bvalid_q <= 1'b1;
            state    <= AXIL_WRITE_RESP;
          end
        end
        AXIL_READ_RESP: begin
          if (s_axi_rready) begin
            rvalid_q <= 1'b0;
            state    <= AXIL_IDLE;
          end
        end
        AXIL_WRITE_RESP: begin
          if (s_axi_bready) begin
            bvalid_q <= 1'b0;
            state    <= AXIL_IDLE;
          end
        end
        default: state <= AXIL_IDLE;
      endcase
    end
  end

  // Request payload, held until the next acceptance
  always_ff @(posedge axi_aclk) begin
    if (rd_accept || wr_accept) begin
      bank_req.write  <= wr_accept;
      bank_req.offset <= acc_addr[`SRAM_ADDR_BITS:1];
      bank_req.wdata  <= s_axi_wdata;
      // Reads enable both bytes
      bank_req.strb   <= rd_accept ? {`SRAM_STRB_BITS{1'b1}} : s_axi_wstrb;
    end
    if (state == AXIL_READ_WAIT && merged_rsp.done) begin
      rdata_q <= merged_rsp.rdata;
    end
  end

  assign s_axi_rvalid = rvalid_q;
  assign s_axi_rdata  = rdata_q;
  assign s_axi_rresp  = 2'b00;
  assign s_axi_bvalid = bvalid_q;
  assign s_axi_bresp  = 2'b00;

endmodule

//--- verilog/axil_sram_top.sv
`include "sram_defines.svh"

module axil_sram_top
  import sram_pkg::*;
(
  input  logic                                        axi_aclk,
  input  logic                                        axi_aresetn,
  input  logic [`AXI_ADDR_BITS-1:0]                   s_axi_awaddr,
  input  logic                                        s_axi_awvalid,
  output logic                                        s_axi_awready,
  input  logic [`SRAM_DATA_BITS-1:0]                  s_axi_wdata,
  input  logic [`SRAM_STRB_BITS-1:0]                  s_axi_wstrb,
  input  logic                                        s_axi_wvalid,
  output logic                                        s_axi_wready,
  output logic [1:0]                                  s_axi_bresp,
  output logic                                        s_axi_bvalid,
  input  logic                                        s_axi_bready,
  input  logic [`AXI_ADDR_BITS-1:0]                   s_axi_araddr,
  input  logic                                        s_axi_arvalid,
  output logic                                        s_axi_arready,
  output logic [`SRAM_DATA_BITS-1:0]                  s_axi_rdata,
  output logic [1:0]                                  s_axi_rresp,
  output logic                                        s_axi_rvalid,
  input  logic                                        s_axi_rready,
  output sram_pins_t [`SRAM_BANKS-1:0]                sram_pins,
  inout  wire [`SRAM_BANKS-1:0][`SRAM_DATA_BITS-1:0]  sram_data
);

  bank_req_t                    bank_req;
  logic [`SRAM_BANKS-1:0]       bank_sel_req;
  bank_rsp_t [`SRAM_BANKS-1:0]  bank_rsp;
  bank_rsp_t                    merged_rsp;

  axil_sram_frontend u_frontend (
    .axi_aclk      (axi_aclk),
    .axi_aresetn   (axi_aresetn),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .bank_req      (bank_req),
    .bank_sel_req  (bank_sel_req),
    .merged_rsp    (merged_rsp)
  );

  // One controller per chip, all sharing the request payload
  for (genvar b = 0; b < `SRAM_BANKS; b++) begin : g_bank
    sram_bank_ctrl u_bank (
      .axi_aclk    (axi_aclk),
      .axi_aresetn (axi_aresetn),
      .req         (bank_req),
      .start       (bank_sel_req[b]),
      .rsp         (bank_rsp[b]),
      .pins        (sram_pins[b]),
      .data        (sram_data[b])
    );
  end

  bank_rsp_merge u_merge (
    .axi_aclk    (axi_aclk),
    .axi_aresetn (axi_aresetn),
    .bank_rsp    (bank_rsp),
    .merged_rsp  (merged_rsp)
  );

endmodule

//--- verilog/bank_rsp_merge.sv
`include "sram_defines.svh"

module bank_rsp_merge
  import sram_pkg::*;
(
  input  logic                          axi_aclk,
  input  logic                          axi_aresetn,
  input  bank_rsp_t [`SRAM_BANKS-1:0]   bank_rsp,
  output bank_rsp_t                     merged_rsp
);

  logic                         any_done;
  logic [`SRAM_DATA_BITS-1:0]   sel_rdata;
  logic                         done_q;
  logic [`SRAM_DATA_BITS-1:0]   rdata_q;

  // Only one bank is ever busy, so an OR of the gated data is enough
  always_comb begin
    any_done  = 1'b0;
    sel_rdata = '0;
    for (int i = 0; i < `SRAM_BANKS; i++) begin
      if (bank_rsp[i].done) begin
        any_done  = 1'b1;
        sel_rdata = sel_rdata | bank_rsp[i].rdata;
      end
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      done_q <= 1'b0;
    end else begin
      done_q <= any_done;
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (any_done) begin
      rdata_q <= sel_rdata;
    end
  end

  assign merged_rsp = '{done: done_q, rdata: rdata_q};

endmodule

//--- verilog/sram_bank_ctrl.sv
`include "sram_defines.svh"

module sram_bank_ctrl
  import sram_pkg::*;
(
  input  logic                        axi_aclk,
  input  logic                        axi_aresetn,
  input  bank_req_t                   req,
  input  logic                        start,
  output bank_rsp_t                   rsp,
  output sram_pins_t                  pins,
  inout  wire [`SRAM_DATA_BITS-1:0]   data
);

  localparam int unsigned CNT_BITS = $clog2(`SRAM_ACCESS_CYCLES + 1);

  bank_state_e                  state;
  logic [CNT_BITS-1:0]          cnt;
  sram_pins_t                   pins_q;
  logic                         drive_q;
  logic                         done_q;
  logic [`SRAM_DATA_BITS-1:0]   wdata_q;
  logic [`SRAM_DATA_BITS-1:0]   rdata_q;

  always_ff @(posedge axi_aclk) begin
    if (!axi_aresetn) begin
      state   <= BANK_IDLE;
      cnt     <= '0;
      pins_q  <= '{addr: '0, ce_n: 1'b1, oe_n: 1'b1, we_n: 1'b1, lb_n: 1'b1, ub_n: 1'b1};
      drive_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        BANK_IDLE: begin
          if (start) begin
            pins_q.addr <= req.offset;
            pins_q.ce_n <= 1'b0;
            pins_q.oe_n <= req.write;
            pins_q.we_n <= !req.write;
            pins_q.lb_n <= !req.strb[0];
            pins_q.ub_n <= !req.strb[1];
            drive_q     <= req.write;
            cnt         <= CNT_BITS'(`SRAM_ACCESS_CYCLES - 1);
            state       <= req.write ? BANK_WRITE : BANK_READ;
          end
        end
        BANK_READ: begin
          if (cnt == '0) begin
            pins_q.ce_n <= 1'b1;
            pins_q.oe_n <= 1'b1;
            pins_q.lb_n <= 1'b1;
            pins_q.ub_n <= 1'b1;
            done_q      <= 1'b1;
            state       <= BANK_IDLE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        BANK_WRITE: begin
          if (cnt == '0) begin
            pins_q.we_n <= 1'b1;
            state       <= BANK_RECOVER;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        // we_n high, data still driven for hold
        BANK_RECOVER: begin
          pins_q.ce_n <= 1'b1;
          pins_q.lb_n <= 1'b1;
          pins_q.ub_n <= 1'b1;
          drive_q     <= 1'b0;
          done_q      <= 1'b1;
          state       <= BANK_IDLE;
        end
        default: state <= BANK_IDLE;
      endcase
    end
  end

  always_ff @(posedge axi_aclk) begin
    if (state == BANK_IDLE && start) begin
      wdata_q <= req.wdata;
    end
    // Sample at the end of the output enable window
    if (state == BANK_READ && cnt == '0) begin
      rdata_q <= data;
    end
  end

  assign data = drive_q ? wdata_q : {`SRAM_DATA_BITS{1'bz}};
  assign pins = pins_q;
  assign rsp  = '{done: done_q, rdata: rdata_q};

endmodule

//--- verilog/sram_defines.svh
`ifndef SRAM_DEFINES_SVH
`define SRAM_DEFINES_SVH

// Chip count and bank select field
`define SRAM_BANKS 4
`define SRAM_BANK_BITS 2

// One 16-bit asynchronous SRAM per bank
`define SRAM_ADDR_BITS 18
`define SRAM_DATA_BITS 16
`define SRAM_STRB_BITS 2

// Byte select + word offset + bank select
`define AXI_ADDR_BITS 21

`define SRAM_ACCESS_CYCLES 2

`endif

//--- verilog/sram_pkg.sv
`include "sram_defines.svh"

package sram_pkg;

  typedef struct packed {
    logic                         write;
    logic [`SRAM_ADDR_BITS-1:0]   offset;
    logic [`SRAM_DATA_BITS-1:0]   wdata;
    logic [`SRAM_STRB_BITS-1:0]   strb;
  } bank_req_t;

  typedef struct packed {
    logic                         done;
    logic [`SRAM_DATA_BITS-1:0]   rdata;
  } bank_rsp_t;

  // Chip control outputs, enables active low
  typedef struct packed {
    logic [`SRAM_ADDR_BITS-1:0]   addr;
    logic                         ce_n;
    logic                         oe_n;
    logic                         we_n;
    logic                         lb_n;
    logic                         ub_n;
  } sram_pins_t;

  typedef enum logic [2:0] {
    AXIL_IDLE,
    AXIL_READ_WAIT,
    AXIL_WRITE_WAIT,
    AXIL_READ_RESP,
    AXIL_WRITE_RESP
  } axil_state_e;

  typedef enum logic [1:0] {
    BANK_IDLE,
    BANK_READ,
    BANK_WRITE,
    BANK_RECOVER
  } bank_state_e;

endpackage
